// File: ifu_macros.svh
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// fetch starts here after reset
`define IFU_PC_INIT 32'h8000_0000

// 4 lines of 2 words in the cache
`define L1I_IDX_W 2
`define L1I_OFS_W 1

// rv32 major opcodes seen by predecode
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// full fence.i encoding
`define INST_FENCE_I 32'h0000_100f

`endif

// File: ifu_pkg.sv
`include "ifu_macros.svh"

package ifu_pkg;

  // instruction word or byte address
  typedef logic [31:0] word_t;

  // address bits left over for the tag
  localparam int unsigned L1I_TAG_W = 32 - `L1I_IDX_W - `L1I_OFS_W - 2;

  typedef logic [L1I_TAG_W-1:0] l1i_tag_t;

  // refill sequence of the instruction cache
  typedef enum logic [2:0] {
    // lookup, start a refill on a miss
    L1I_IDLE,
    // even word read outstanding
    L1I_REQ0,
    // one idle cycle between the two reads
    L1I_GAP,
    // odd word read outstanding
    L1I_REQ1,
    // line just written, lookup allowed again
    L1I_DONE
  } l1i_state_e;

endpackage

// File: l1i_req_if.sv
`timescale 1ns/1ps

interface l1i_req_if;
  import ifu_pkg::*;

  // controller side
  word_t fetch_pc;
  logic  flush;

  // cache side
  word_t inst;
  logic  hit;
  logic  idle;

  modport ctrl (
    output fetch_pc,
    output flush,
    input  inst,
    input  hit,
    input  idle
  );

  modport cache (
    input  fetch_pc,
    input  flush,
    output inst,
    output hit,
    output idle
  );

endinterface

// File: ifu_l1i.sv
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_l1i (
  input  logic           clk,
  input  logic           rst,
  l1i_req_if.cache       req,
  output ifu_pkg::word_t araddr_o,
  output logic           arvalid_o,
  input  ifu_pkg::word_t rdata_i,
  input  logic           rvalid_i
);
  import ifu_pkg::*;

  localparam int unsigned LINES  = 1 << `L1I_IDX_W;
  localparam int unsigned WORDS  = 1 << `L1I_OFS_W;
  localparam int unsigned IDX_LO = `L1I_OFS_W + 2;
  localparam int unsigned TAG_LO = `L1I_IDX_W + `L1I_OFS_W + 2;

  // storage
  word_t            data_q  [LINES][WORDS];
  l1i_tag_t         tag_q   [LINES][WORDS];
  logic [LINES-1:0] valid_q;

  l1i_state_e state_q;

  // address split
  l1i_tag_t              addr_tag;
  logic [`L1I_IDX_W-1:0] addr_idx;
  logic [`L1I_OFS_W-1:0] addr_ofs;

  logic  lookup;
  logic  hit;
  word_t line_base;
  logic  odd_word;

  assign addr_tag = req.fetch_pc[31:TAG_LO];
  assign addr_idx = req.fetch_pc[TAG_LO-1:IDX_LO];
  assign addr_ofs = req.fetch_pc[IDX_LO-1:2];

  // tag compare only outside of a refill
  assign lookup = (state_q == L1I_IDLE) || (state_q == L1I_DONE);
  assign hit    = lookup && valid_q[addr_idx] &&
                  (tag_q[addr_idx][addr_ofs] == addr_tag);

  assign req.hit  = hit;
  assign req.inst = data_q[addr_idx][addr_ofs];
  assign req.idle = (state_q == L1I_IDLE);

  // even word first, then the odd one
  assign line_base = {req.fetch_pc[31:IDX_LO], {IDX_LO{1'b0}}};
  assign odd_word  = (state_q == L1I_GAP) || (state_q == L1I_REQ1) ||
                     (state_q == L1I_DONE);
  assign araddr_o  = odd_word ? (line_base | word_t'(4)) : line_base;

  // held until the matching rvalid_i
  assign arvalid_o = !hit && ((state_q == L1I_IDLE) || (state_q == L1I_REQ0) ||
                              (state_q == L1I_REQ1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= L1I_IDLE;
      valid_q <= '0;
    end else begin
      // fence.i drops the whole cache
      if (req.flush) begin
        valid_q <= '0;
      end
      case (state_q)
        L1I_IDLE: begin
          if (arvalid_o) begin
            state_q <= L1I_REQ0;
          end
        end
        L1I_REQ0: begin
          if (rvalid_i) begin
            state_q <= L1I_GAP;
          end
        end
        L1I_GAP: begin
          state_q <= L1I_REQ1;
        end
        L1I_REQ1: begin
          if (rvalid_i) begin
            state_q          <= L1I_DONE;
            valid_q[addr_idx] <= 1'b1;
          end
        end
        L1I_DONE: begin
          state_q <= L1I_IDLE;
        end
        default: begin
          state_q <= L1I_IDLE;
        end
      endcase
    end
  end

  // line data and tags
  always_ff @(posedge clk) begin
    if (rvalid_i && (state_q == L1I_REQ0)) begin
      data_q[addr_idx][0] <= rdata_i;
      tag_q[addr_idx][0]  <= addr_tag;
    end
    if (rvalid_i && (state_q == L1I_REQ1)) begin
      data_q[addr_idx][1] <= rdata_i;
      tag_q[addr_idx][1]  <= addr_tag;
    end
  end

  // an outstanding read keeps its request and address
  a_read_held: assert property (
    @(posedge clk) disable iff (rst)
    (arvalid_o && !rvalid_i && (state_q inside {L1I_REQ0, L1I_REQ1}))
      |=> (arvalid_o && $stable(araddr_o))
  );

  // responses only while a read is outstanding
  a_rvalid_in_req: assert property (
    @(posedge clk) disable iff (rst)
    rvalid_i |-> (state_q inside {L1I_REQ0, L1I_REQ1})
  );

endmodule

// File: ifu_ctrl.sv
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_ctrl (
  input  logic           clk,
  input  logic           rst,
  l1i_req_if.ctrl        req,
  input  ifu_pkg::word_t npc_i,
  input  ifu_pkg::word_t pc_i,
  input  logic           pc_change_i,
  input  logic           pc_retire_i,
  input  logic           next_ready_i,
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::word_t pc_o,
  output logic           valid_o,
  output logic           speculation_o,
  output logic           good_speculation_o,
  output logic           bad_speculation_o
);
  import ifu_pkg::*;

  // fetch pc and hazard stall
  word_t pc_q;
  logic  hazard_q;
  logic  hz_pend_q;
  word_t hz_pc_q;

  // one-entry branch target register
  word_t btb_q;
  logic  btb_valid_q;

  // guess in flight
  logic  spec_q;
  word_t spec_pc_q;
  word_t spec_fall_q;
  logic  spec_cond_q;
  logic  good_q;
  logic  bad_q;
  word_t bad_pc_q;

  logic [6:0] opcode;
  logic       is_cti;
  logic       is_load;
  logic       is_store;
  logic       is_fence;
  logic       accept;
  logic       start_spec;
  logic       resolve;
  word_t      resolved_pc;
  logic       spec_good;
  logic       spec_bad;
  word_t      bad_pc;
  word_t      bad_target;
  logic       redirect;
  logic       hz_res;
  word_t      hz_pc;

  // predecode
  assign opcode   = req.inst[6:0];
  assign is_cti   = (opcode == `OP_JAL) || (opcode == `OP_JALR) ||
                    (opcode == `OP_BRANCH) || (opcode == `OP_SYSTEM);
  assign is_load  = (opcode == `OP_LOAD);
  assign is_store = (opcode == `OP_STORE);
  assign is_fence = (req.inst == `INST_FENCE_I);

  // what the core says comes next
  assign resolve     = pc_change_i || pc_retire_i;
  assign resolved_pc = pc_change_i ? npc_i : pc_i + 32'd4;

  assign spec_good = spec_q && resolve && (resolved_pc == spec_pc_q);
  assign spec_bad  = spec_q && resolve && (resolved_pc != spec_pc_q);

  // not-taken conditional branch goes back to the fallthrough
  assign bad_pc     = (pc_change_i || !spec_cond_q) ? npc_i : spec_fall_q;
  assign bad_target = bad_q ? bad_pc_q : bad_pc;
  assign redirect   = bad_speculation_o && next_ready_i && req.idle;

  // stall released by the first resolution outside a guess
  assign hz_res = hazard_q && !hz_pend_q && !spec_q && !bad_q && resolve;
  assign hz_pc  = pc_change_i ? npc_i : pc_q + 32'd4;

  assign bad_speculation_o  = bad_q || spec_bad;
  assign good_speculation_o = good_q;
  assign speculation_o      = spec_q;

  // memory ops wait until the guess is settled
  assign valid_o = req.hit && !hazard_q && !bad_speculation_o &&
                   !(spec_q && (is_load || is_store));
  assign accept     = valid_o && next_ready_i;
  assign start_spec = accept && is_cti && btb_valid_q && !spec_q;

  assign inst_o       = req.inst;
  assign pc_o         = pc_q;
  assign req.fetch_pc = pc_q;
  assign req.flush    = accept && is_fence;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `IFU_PC_INIT;
      hazard_q    <= 1'b0;
      hz_pend_q   <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= spec_good;
      if (spec_good || spec_bad) begin
        spec_q <= 1'b0;
      end
      if (spec_bad && !redirect) begin
        bad_q <= 1'b1;
      end
      if (pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      // pc must not move under a refill, so park the target
      if (hz_res) begin
        if (req.idle) begin
          pc_q     <= hz_pc;
          hazard_q <= 1'b0;
        end else begin
          hz_pend_q <= 1'b1;
        end
      end
      if (hz_pend_q && req.idle) begin
        pc_q      <= hz_pc_q;
        hazard_q  <= 1'b0;
        hz_pend_q <= 1'b0;
      end
      if (accept) begin
        if (is_cti) begin
          if (start_spec) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else begin
            hazard_q <= 1'b1;
          end
        end else if (is_load || is_fence) begin
          hazard_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
      // wrong path is dropped here
      if (redirect) begin
        pc_q      <= bad_target;
        bad_q     <= 1'b0;
        spec_q    <= 1'b0;
        hazard_q  <= 1'b0;
        hz_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pc_change_i) begin
      btb_q <= npc_i;
    end
    if (hz_res) begin
      hz_pc_q <= hz_pc;
    end
    if (spec_bad) begin
      bad_pc_q <= bad_pc;
    end
    if (start_spec) begin
      spec_pc_q   <= btb_q;
      spec_fall_q <= pc_q + 32'd4;
      spec_cond_q <= (opcode == `OP_BRANCH);
    end
  end

  a_spec_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(good_speculation_o && bad_speculation_o)
  );

  // wrong path stays blocked until the redirect
  a_bad_held: assert property (
    @(posedge clk) disable iff (rst)
    (bad_speculation_o && !redirect) |=> bad_speculation_o
  );

endmodule

// File: ifu_top.sv
`timescale 1ns/1ps

module ifu_top (
  input  logic           clk,
  input  logic           rst,

  // instruction read bus
  output ifu_pkg::word_t araddr_o,
  output logic           arvalid_o,
  input  ifu_pkg::word_t rdata_i,
  input  logic           rvalid_i,

  // redirect and retirement from the core
  input  ifu_pkg::word_t npc_i,
  input  ifu_pkg::word_t pc_i,
  input  logic           pc_change_i,
  input  logic           pc_retire_i,

  // decode handshake
  input  logic           next_ready_i,
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::word_t pc_o,
  output logic           valid_o,

  output logic           speculation_o,
  output logic           good_speculation_o,
  output logic           bad_speculation_o
);

  l1i_req_if req_if ();

  ifu_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .req                (req_if.ctrl),
    .npc_i              (npc_i),
    .pc_i               (pc_i),
    .pc_change_i        (pc_change_i),
    .pc_retire_i        (pc_retire_i),
    .next_ready_i       (next_ready_i),
    .inst_o             (inst_o),
    .pc_o               (pc_o),
    .valid_o            (valid_o),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o)
  );

  ifu_l1i u_l1i (
    .clk       (clk),
    .rst       (rst),
    .req       (req_if.cache),
    .araddr_o  (araddr_o),
    .arvalid_o (arvalid_o),
    .rdata_i   (rdata_i),
    .rvalid_i  (rvalid_i)
  );

endmodule

// File: tb_ifu.sv
`timescale 1ns/1ps
`include "ifu_macros.svh"

module tb_ifu;

  localparam int HALF      = 20;
  localparam int DRIVE_DLY = 5;
  localparam int STEP_BASE = 'h20;
  localparam int MAX_WAIT  = 400;

  logic        clk;
  logic        rst;
  logic [31:0] araddr_o;
  logic        arvalid_o;
  logic [31:0] rdata_i;
  logic        rvalid_i;
  logic [31:0] npc_i;
  logic [31:0] pc_i;
  logic        pc_change_i;
  logic        pc_retire_i;
  logic        next_ready_i;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        speculation_o;
  logic        good_speculation_o;
  logic        bad_speculation_o;

  logic [31:0] td [0:255];
  logic [31:0] lfsr_q;
  logic        odd_next;
  logic [31:0] first_addr;
  int          reads_since;

  // core model state
  logic        pend;
  logic [1:0]  pend_kind;
  logic [31:0] pend_npc;
  logic [31:0] pend_pc;
  int          pend_cnt;
  int          hold_left;
  logic        held;
  logic [31:0] held_pc;
  logic [31:0] held_inst;
  logic        bad_prev;
  logic        spec_prev;
  int          good_cnt;
  int          bad_cnt;
  int          spec_cnt;

  ifu_top DUT (
    .clk                (clk),
    .rst                (rst),
    .araddr_o           (araddr_o),
    .arvalid_o          (arvalid_o),
    .rdata_i            (rdata_i),
    .rvalid_i           (rvalid_i),
    .npc_i              (npc_i),
    .pc_i               (pc_i),
    .pc_change_i        (pc_change_i),
    .pc_retire_i        (pc_retire_i),
    .next_ready_i       (next_ready_i),
    .inst_o             (inst_o),
    .pc_o               (pc_o),
    .valid_o            (valid_o),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o)
  );

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  task automatic fail_stop();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task take_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
  endtask

  // even word of the line first, then the odd one
  task answer_read();
    logic [31:0] ofs;
    ofs = araddr_o - `IFU_PC_INIT;
    if (!odd_next) begin
      assert (araddr_o[2] == 1'b0) else begin
        $display("error at %0t ns: araddr_o[2] is %b, expected %b", $time, araddr_o[2], 1'b0);
        fail_stop();
      end
      first_addr = araddr_o;
    end else begin
      assert (araddr_o == first_addr + 32'd4) else begin
        $display("error at %0t ns: araddr_o is %h, expected %h", $time, araddr_o,
                 first_addr + 32'd4);
        fail_stop();
      end
    end
    odd_next = !odd_next;
    assert (ofs < 64) else begin
      $display("bus read at %h lies outside the program image", araddr_o);
      fail_stop();
    end
    rdata_i     = td[ofs >> 2];
    rvalid_i    = 1'b1;
    reads_since = reads_since + 1;
  endtask

  initial begin : memory_model
    logic [1:0] dly;
    logic       b;
    rdata_i  = '0;
    rvalid_i = 1'b0;
    odd_next = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && arvalid_o) begin
        take_bit(b);
        dly[0] = b;
        take_bit(b);
        dly[1] = b;
        @(posedge clk);
        #DRIVE_DLY;
        repeat (dly) begin
          @(posedge clk);
          #DRIVE_DLY;
        end
        answer_read();
        @(posedge clk);
        #DRIVE_DLY;
        rvalid_i = 1'b0;
      end
    end
  end

  task drive_cycle();
    logic b;
    take_bit(b);
    next_ready_i = (hold_left != 0) ? 1'b0 : b;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    npc_i        = '0;
    pc_i         = '0;
    if (pend) begin
      if (pend_cnt == 0) begin
        pend = 1'b0;
        if (pend_kind == 2'd1) begin
          pc_retire_i = 1'b1;
          pc_i        = pend_pc;
        end else begin
          pc_change_i = 1'b1;
          npc_i       = pend_npc;
        end
      end else begin
        pend_cnt = pend_cnt - 1;
      end
    end
  endtask

  task check_accept(input int k);
    int          base;
    logic [31:0] flag;
    base = STEP_BASE + 6 * k;
    flag = td[base + 5];
    assert (pc_o == td[base]) else begin
      $display("error at %0t ns: pc_o is %h, expected %h", $time, pc_o, td[base]);
      fail_stop();
    end
    assert (inst_o == td[base + 1]) else begin
      $display("error at %0t ns: inst_o is %h, expected %h", $time, inst_o, td[base + 1]);
      fail_stop();
    end
    assert (!(speculation_o && (inst_o[6:0] inside {`OP_LOAD, `OP_STORE}))) else begin
      $display("memory instruction at %h was passed to decode during speculation", pc_o);
      fail_stop();
    end
    if (flag == 1) begin
      assert (reads_since == 0) else begin
        $display("error at %0t ns: arvalid_o reads before %h is %0d, expected 0", $time,
                 pc_o, reads_since);
        fail_stop();
      end
    end
    if (flag == 2) begin
      assert (reads_since != 0) else begin
        $display("missed pc %h was served without any bus read", pc_o);
        fail_stop();
      end
    end
    reads_since = 0;
    if (td[base + 2] != 0) begin
      assert (!pend) else begin
        $display("core response still pending when step %0d was accepted", k);
        fail_stop();
      end
      pend      = 1'b1;
      pend_kind = td[base + 2][1:0];
      pend_npc  = td[base + 3];
      pend_pc   = pc_o;
      pend_cnt  = td[base + 4];
    end
  endtask

  task sample_cycle(input int k, output logic acc);
    acc = 1'b0;
    if (bad_speculation_o && !bad_prev) begin
      bad_cnt = bad_cnt + 1;
    end
    bad_prev = bad_speculation_o;
    // every guess starts once and ends good or bad
    if (speculation_o && !spec_prev) begin
      spec_cnt = spec_cnt + 1;
    end
    spec_prev = speculation_o;
    if (good_speculation_o) begin
      good_cnt = good_cnt + 1;
    end
    if (valid_o && hold_left != 0) begin
      hold_left = hold_left - 1;
    end
    // back-pressure keeps the offered instruction
    if (held && valid_o) begin
      assert (pc_o == held_pc && inst_o == held_inst) else begin
        $display("error at %0t ns: pc_o/inst_o is %h/%h, expected %h/%h", $time, pc_o,
                 inst_o, held_pc, held_inst);
        fail_stop();
      end
    end
    held      = valid_o && !next_ready_i;
    held_pc   = pc_o;
    held_inst = inst_o;
    if (valid_o && next_ready_i) begin
      acc = 1'b1;
      check_accept(k);
    end
  endtask

  initial begin : core_model
    int   k;
    int   n_steps;
    int   waited;
    logic acc;
    rst          = 1'b1;
    next_ready_i = 1'b0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    npc_i        = '0;
    pc_i         = '0;
    lfsr_q       = 32'h346c6cfc;
    reads_since  = 0;
    pend         = 1'b0;
    hold_left    = 6;
    held         = 1'b0;
    bad_prev     = 1'b0;
    spec_prev    = 1'b0;
    good_cnt     = 0;
    bad_cnt      = 0;
    spec_cnt     = 0;
    $readmemh("ifu_testdata.txt", td);
    n_steps = td['h10];
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    for (k = 0; k < n_steps; k++) begin
      waited = 0;
      acc    = 1'b0;
      while (!acc) begin
        @(posedge clk);
        #DRIVE_DLY;
        drive_cycle();
        @(negedge clk);
        sample_cycle(k, acc);
        waited = waited + 1;
        assert (acc || waited < MAX_WAIT) else begin
          $display("timeout: step %0d was not accepted within %0d cycles", k, MAX_WAIT);
          fail_stop();
        end
      end
    end
    assert (good_cnt == td['h11]) else begin
      $display("error at %0t ns: good_speculation_o cycles %0d, expected %0d", $time,
               good_cnt, td['h11]);
      fail_stop();
    end
    assert (bad_cnt == td['h12]) else begin
      $display("error at %0t ns: bad_speculation_o events %0d, expected %0d", $time,
               bad_cnt, td['h12]);
      fail_stop();
    end
    assert (spec_cnt == td['h11] + td['h12]) else begin
      $display("error at %0t ns: speculation_o starts %0d, expected %0d", $time,
               spec_cnt, td['h11] + td['h12]);
      fail_stop();
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
ifu_pkg.sv
l1i_req_if.sv
ifu_l1i.sv
ifu_ctrl.sv
ifu_top.sv
tb_ifu.sv

// File: Bender.yml
package:
  name: ifu_fetch

export_include_dirs:
  - .

sources:
  - files:
      - ifu_pkg.sv
      - l1i_req_if.sv
      - ifu_l1i.sv
      - ifu_ctrl.sv
      - ifu_top.sv
  - target: test
    files:
      - tb_ifu.sv

// File: ifu_testdata.txt
// image words from @00, then step count, good pulses and bad events at @10
// steps from @20, one per line: pc inst resp npc delay flag
// resp 0 none, 1 retire, 2 change to npc; flag 1 no bus read, 2 bus reads before it
@00
00108093 00208093 00308093 fe009ae3
0080006f 00908093 00002103 00008067
0000100f 00408093 00508093 00608093
00000013 00000013 00000013 00000013
@10
00000011 00000001 00000003
@20
80000000 00108093 0 00000000 0 2
80000004 00208093 0 00000000 0 1
80000008 00308093 0 00000000 0 2
8000000c fe009ae3 2 80000000 0 1
80000000 00108093 0 00000000 0 1
80000004 00208093 0 00000000 0 1
80000008 00308093 0 00000000 0 1
8000000c fe009ae3 1 00000000 0 1
80000010 0080006f 2 80000018 0 2
80000018 00002103 1 00000000 0 2
8000001c 00008067 2 80000018 3 1
80000018 00002103 1 00000000 0 1
8000001c 00008067 2 80000020 0 1
80000020 0000100f 1 00000000 0 2
80000024 00408093 0 00000000 0 2
80000028 00508093 0 00000000 0 2
8000002c 00608093 0 00000000 0 1
